/* common/pe_pkg.sv */
package pe_pkg;

  localparam int MEM_WIDTH = 32;  // data bus and flit width
  localparam int MEM_DEPTH = 256;  // scratchpad words
  localparam int MEM_AW = 8;
  localparam int CPU_AW = 12;
  localparam logic [CPU_AW-1:0] MEM_BASE = 12'h000;
  localparam int REG_SEL_BIT = 11;  // set means register region
  localparam int LINK_CREDITS = 4;  // receiver buffer depth per link
  localparam int CREDIT_W = $clog2(LINK_CREDITS + 1);
  localparam logic [CREDIT_W-1:0] CREDIT_INIT = CREDIT_W'(LINK_CREDITS);
  localparam int STATUS_W = 3;  // busy, rx_done, tx_done

  // only write packets exist, anything else gets dropped
  typedef enum logic [7:0] {
    PKT_WRITE = 8'h01
  } pkt_type_e;

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_HEADER,
    TX_ADDR,
    TX_DATA,
    TX_DONE
  } ddma_tx_state_e;

  typedef enum logic [2:0] {
    RX_HEADER,
    RX_ADDR,
    RX_DATA,
    RX_DROP
  } ddma_rx_state_e;

  // word offsets inside the register region
  typedef enum logic [3:0] {
    REG_DEST_NODE = 4'd0,
    REG_LOCAL_ADDR = 4'd1,
    REG_REMOTE_ADDR = 4'd2,
    REG_LENGTH = 4'd3,
    REG_START = 4'd4,
    REG_STATUS = 4'd5,
    REG_IRQ_EN = 4'd6,
    REG_IRQ_CLR = 4'd7
  } reg_addr_e;

  typedef struct packed {
    pkt_type_e opcode;
    logic [7:0] length;  // data flits
    logic [7:0] src_node;
    logic [7:0] dest_node;
  } flit_hdr_t;

  typedef struct packed {
    logic write;
    logic [CPU_AW-1:0] addr;
    logic [MEM_WIDTH-1:0] wdata;
  } cpu_req_t;

  typedef struct packed {
    logic [MEM_WIDTH-1:0] rdata;
  } cpu_rsp_t;

  typedef struct packed {
    logic en;
    logic we;
    logic [MEM_AW-1:0] addr;
    logic [MEM_WIDTH-1:0] data;
  } mem_req_t;

  typedef struct packed {
    logic [7:0] dest_node;
    logic [7:0] local_addr;
    logic [7:0] remote_addr;
    logic [7:0] length;
  } ddma_cmd_t;

  typedef struct packed {
    logic tx;  // flit valid
    logic [MEM_WIDTH-1:0] data;
  } link_t;

endpackage

/* hw/dual_port_ram.sv */
`timescale 1ns/1ns

module dual_port_ram (
  input  logic clk_i,
  input  pe_pkg::mem_req_t port_a_i,  // ddma side
  input  pe_pkg::mem_req_t port_b_i,  // mmio side
  output logic [pe_pkg::MEM_WIDTH-1:0] rdata_a_o,
  output logic [pe_pkg::MEM_WIDTH-1:0] rdata_b_o
);

  logic [pe_pkg::MEM_WIDTH-1:0] mem [pe_pkg::MEM_DEPTH];

  // read-first on both ports, one cycle latency
  always_ff @(posedge clk_i) begin
    if (port_a_i.en) begin
      if (port_a_i.we) begin
        mem[port_a_i.addr] <= port_a_i.data;
      end
      rdata_a_o <= mem[port_a_i.addr];
    end
    if (port_b_i.en) begin
      if (port_b_i.we) begin
        mem[port_b_i.addr] <= port_b_i.data;
      end
      rdata_b_o <= mem[port_b_i.addr];
    end
  end

  // the cpu and an incoming packet must not collide on a word
  a_no_write_clash: assert property (
    @(posedge clk_i)
    !(port_a_i.en && port_a_i.we && port_b_i.en && port_b_i.we &&
      port_a_i.addr == port_b_i.addr)
  ) else $error("dual_port_ram: both ports write address %0h", port_a_i.addr);

endmodule

/* hw/ddma/ddma.sv */
`timescale 1ns/1ns

module ddma #(
  parameter logic [7:0] NODE_ADDR = 8'h00
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  pe_pkg::ddma_cmd_t cmd_i,
  input  logic cmd_valid_i,
  output logic cmd_ready_o,
  output pe_pkg::mem_req_t mem_o,
  input  logic [pe_pkg::MEM_WIDTH-1:0] mem_rdata_i,
  output pe_pkg::link_t link_o,
  input  logic credit_i,
  input  pe_pkg::link_t link_i,
  output logic credit_o,
  output logic tx_done_o,
  output logic rx_done_o
);

  pe_pkg::ddma_tx_state_e tx_state_q;
  pe_pkg::ddma_rx_state_e rx_state_q;
  pe_pkg::ddma_cmd_t cmd_q;
  pe_pkg::flit_hdr_t tx_hdr;
  pe_pkg::flit_hdr_t rx_hdr;
  logic [pe_pkg::CREDIT_W-1:0] credit_cnt_q;
  logic [pe_pkg::MEM_AW-1:0] rd_addr_q;
  logic [pe_pkg::MEM_AW-1:0] wr_addr_q;
  logic [7:0] rd_left_q;
  logic [7:0] tx_left_q;
  logic [8:0] rx_left_q;  // a dropped packet also counts its address flit
  logic rd_pend_q;  // read issued last cycle, data on mem_rdata_i
  logic hold_v_q;
  logic [pe_pkg::MEM_WIDTH-1:0] hold_q;
  logic link_tx_q;
  logic [pe_pkg::MEM_WIDTH-1:0] link_data_q;
  logic credit_q;
  logic tx_send;
  logic data_send;
  logic rd_issue;
  logic rx_wr;
  logic [pe_pkg::MEM_WIDTH-1:0] tx_flit;

  assign cmd_ready_o = (tx_state_q == pe_pkg::TX_IDLE);
  assign tx_done_o = (tx_state_q == pe_pkg::TX_DONE);
  assign link_o = '{tx: link_tx_q, data: link_data_q};
  assign credit_o = credit_q;

  assign tx_hdr = '{
    opcode: pe_pkg::PKT_WRITE,
    length: cmd_q.length,
    src_node: NODE_ADDR,
    dest_node: cmd_q.dest_node
  };
  assign rx_hdr = pe_pkg::flit_hdr_t'(link_i.data);

  // data flit comes from the holding register or straight from the ram
  assign data_send = (tx_state_q == pe_pkg::TX_DATA) && (hold_v_q || rd_pend_q) &&
                     (credit_cnt_q != '0);
  // at most one word in flight or held, receive side owns the port first
  assign rd_issue = (tx_state_q == pe_pkg::TX_DATA) && (rd_left_q != '0) && !rx_wr &&
                    (!(hold_v_q || rd_pend_q) || data_send);
  assign rx_wr = (rx_state_q == pe_pkg::RX_DATA) && link_i.tx;

  always_comb begin
    tx_send = 1'b0;
    tx_flit = hold_v_q ? hold_q : mem_rdata_i;
    case (tx_state_q)
      pe_pkg::TX_HEADER: begin
        tx_send = (credit_cnt_q != '0);
        tx_flit = tx_hdr;
      end
      pe_pkg::TX_ADDR: begin
        tx_send = (credit_cnt_q != '0);
        tx_flit = {24'b0, cmd_q.remote_addr};  // zero extended
      end
      pe_pkg::TX_DATA: tx_send = data_send;
      default: ;
    endcase
  end

  always_comb begin
    mem_o.en = rx_wr || rd_issue;
    mem_o.we = rx_wr;
    mem_o.addr = rx_wr ? wr_addr_q : rd_addr_q;
    mem_o.data = link_i.data;
  end

  assign rx_done_o = link_i.tx &&
                     (((rx_state_q == pe_pkg::RX_DATA) && (rx_left_q == 9'd1)) ||
                      ((rx_state_q == pe_pkg::RX_ADDR) && (rx_left_q == 9'd0)));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tx_state_q <= pe_pkg::TX_IDLE;
      credit_cnt_q <= pe_pkg::CREDIT_INIT;
      rd_pend_q <= 1'b0;
      hold_v_q <= 1'b0;
      link_tx_q <= 1'b0;
      rd_left_q <= '0;
      tx_left_q <= '0;
    end else begin
      credit_cnt_q <= credit_cnt_q - tx_send + credit_i;
      link_tx_q <= tx_send;
      rd_pend_q <= rd_issue;
      hold_v_q <= (hold_v_q || rd_pend_q) && !data_send;
      if (rd_issue) rd_left_q <= rd_left_q - 8'd1;
      if (data_send) tx_left_q <= tx_left_q - 8'd1;
      case (tx_state_q)
        pe_pkg::TX_IDLE: begin
          if (cmd_valid_i) begin
            rd_left_q <= cmd_i.length;
            tx_left_q <= cmd_i.length;
            tx_state_q <= pe_pkg::TX_HEADER;
          end
        end
        pe_pkg::TX_HEADER: if (tx_send) tx_state_q <= pe_pkg::TX_ADDR;
        pe_pkg::TX_ADDR: begin
          if (tx_send) begin
            tx_state_q <= (cmd_q.length == '0) ? pe_pkg::TX_DONE : pe_pkg::TX_DATA;
          end
        end
        pe_pkg::TX_DATA: if (data_send && tx_left_q == 8'd1) tx_state_q <= pe_pkg::TX_DONE;
        default: tx_state_q <= pe_pkg::TX_IDLE;  // done pulse lasts one cycle
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    link_data_q <= tx_flit;
    if (cmd_valid_i && cmd_ready_o) begin
      cmd_q <= cmd_i;
      rd_addr_q <= cmd_i.local_addr;
    end else if (rd_issue) begin
      rd_addr_q <= rd_addr_q + 8'd1;
    end
    if (rd_pend_q && !data_send) hold_q <= mem_rdata_i;
  end

  // every flit is consumed on arrival, so credits go straight back
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rx_state_q <= pe_pkg::RX_HEADER;
      credit_q <= 1'b0;
      rx_left_q <= '0;
    end else begin
      credit_q <= link_i.tx;
      if (link_i.tx) begin
        case (rx_state_q)
          pe_pkg::RX_HEADER: begin
            if (rx_hdr.opcode == pe_pkg::PKT_WRITE) begin
              rx_left_q <= {1'b0, rx_hdr.length};
              rx_state_q <= pe_pkg::RX_ADDR;
            end else begin
              rx_left_q <= {1'b0, rx_hdr.length} + 9'd1;
              rx_state_q <= pe_pkg::RX_DROP;
            end
          end
          pe_pkg::RX_ADDR: begin
            rx_state_q <= (rx_left_q == '0) ? pe_pkg::RX_HEADER : pe_pkg::RX_DATA;
          end
          default: begin  // data or drop
            rx_left_q <= rx_left_q - 9'd1;
            if (rx_left_q == 9'd1) rx_state_q <= pe_pkg::RX_HEADER;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (link_i.tx && rx_state_q == pe_pkg::RX_ADDR) begin
      wr_addr_q <= link_i.data[pe_pkg::MEM_AW-1:0];
    end else if (rx_wr) begin
      wr_addr_q <= wr_addr_q + 8'd1;  // wraps at MEM_DEPTH
    end
  end

  a_credit_before_flit: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    link_o.tx |-> $past(credit_cnt_q) != '0
  ) else $error("ddma: flit sent without credit");

  // peer returned more credits than it has buffer slots
  a_credit_bound: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    credit_cnt_q <= pe_pkg::LINK_CREDITS
  ) else $error("ddma: credit counter at %0d", credit_cnt_q);

endmodule

/* hw/tcd.sv */
`timescale 1ns/1ns

module tcd #(
  parameter logic [7:0] NODE_ADDR = 8'h00
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  pe_pkg::cpu_req_t reg_req_i,
  input  logic reg_sel_i,
  output logic [pe_pkg::MEM_WIDTH-1:0] reg_rdata_o,
  output pe_pkg::ddma_cmd_t cmd_o,
  output logic cmd_valid_o,
  input  logic cmd_ready_i,
  input  logic tx_done_i,
  input  logic rx_done_i,
  output logic irq_o
);

  pe_pkg::reg_addr_e offset;
  logic wr;
  logic [7:0] dest_q, local_q, remote_q, length_q;
  logic cmd_valid_q;
  logic busy_q, tx_done_q, rx_done_q;
  logic [pe_pkg::STATUS_W-1:0] irq_en_q;
  logic [pe_pkg::STATUS_W-1:0] status;
  logic irq_q;
  logic [pe_pkg::MEM_WIDTH-1:0] rd_mux;

  assign offset = pe_pkg::reg_addr_e'(reg_req_i.addr[3:0]);
  assign wr = reg_sel_i && reg_req_i.write;
  assign status = {busy_q, rx_done_q, tx_done_q};
  assign cmd_o = '{dest_node: dest_q, local_addr: local_q, remote_addr: remote_q,
                   length: length_q};
  assign cmd_valid_o = cmd_valid_q;
  assign irq_o = irq_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cmd_valid_q <= 1'b0;
      busy_q <= 1'b0;
      tx_done_q <= 1'b0;
      rx_done_q <= 1'b0;
      irq_en_q <= '0;
      irq_q <= 1'b0;
    end else begin
      irq_q <= |(status & irq_en_q);
      if (cmd_valid_q && cmd_ready_i) cmd_valid_q <= 1'b0;
      if (tx_done_i) busy_q <= 1'b0;
      if (wr) begin
        case (offset)
          pe_pkg::REG_START: begin
            if (!busy_q) begin  // a start while busy is ignored
              cmd_valid_q <= 1'b1;
              busy_q <= 1'b1;
            end
          end
          pe_pkg::REG_IRQ_EN: irq_en_q <= reg_req_i.wdata[pe_pkg::STATUS_W-1:0];
          pe_pkg::REG_IRQ_CLR: begin
            tx_done_q <= tx_done_q & ~reg_req_i.wdata[0];
            rx_done_q <= rx_done_q & ~reg_req_i.wdata[1];
          end
          default: ;
        endcase
      end
      // a new done event beats a clear in the same cycle
      if (tx_done_i) tx_done_q <= 1'b1;
      if (rx_done_i) rx_done_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr && offset == pe_pkg::REG_DEST_NODE) dest_q <= reg_req_i.wdata[7:0];
    if (wr && offset == pe_pkg::REG_LOCAL_ADDR) local_q <= reg_req_i.wdata[7:0];
    if (wr && offset == pe_pkg::REG_REMOTE_ADDR) remote_q <= reg_req_i.wdata[7:0];
    if (wr && offset == pe_pkg::REG_LENGTH) length_q <= reg_req_i.wdata[7:0];
    if (reg_sel_i && !reg_req_i.write) reg_rdata_o <= rd_mux;
  end

  always_comb begin
    case (offset)
      pe_pkg::REG_DEST_NODE: rd_mux = {24'b0, dest_q};
      pe_pkg::REG_LOCAL_ADDR: rd_mux = {24'b0, local_q};
      pe_pkg::REG_REMOTE_ADDR: rd_mux = {24'b0, remote_q};
      pe_pkg::REG_LENGTH: rd_mux = {24'b0, length_q};
      pe_pkg::REG_STATUS: rd_mux = {16'b0, NODE_ADDR, 5'b0, status};  // own node id too
      pe_pkg::REG_IRQ_EN: rd_mux = {29'b0, irq_en_q};
      default: rd_mux = '0;
    endcase
  end

endmodule

/* hw/mmio.sv */
`timescale 1ns/1ns

module mmio (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic cpu_req_valid_i,
  input  pe_pkg::cpu_req_t cpu_req_i,
  output logic cpu_req_ready_o,
  output logic cpu_rsp_valid_o,
  output pe_pkg::cpu_rsp_t cpu_rsp_o,
  output pe_pkg::mem_req_t mem_o,
  input  logic [pe_pkg::MEM_WIDTH-1:0] mem_rdata_i,
  output pe_pkg::cpu_req_t reg_req_o,
  output logic reg_sel_o,
  input  logic [pe_pkg::MEM_WIDTH-1:0] reg_rdata_i
);

  logic req_acc;
  logic rd_acc;
  logic is_reg;
  logic ready_q;
  logic rsp_valid_q;
  logic rsp_reg_q;  // pending read targets the registers
  logic [pe_pkg::CPU_AW-1:0] mem_off;

  assign req_acc = cpu_req_valid_i && ready_q;
  assign rd_acc = req_acc && !cpu_req_i.write;
  assign is_reg = cpu_req_i.addr[pe_pkg::REG_SEL_BIT];
  assign mem_off = cpu_req_i.addr - pe_pkg::MEM_BASE;

  always_comb begin
    mem_o.en = req_acc && !is_reg;
    mem_o.we = cpu_req_i.write;
    mem_o.addr = mem_off[pe_pkg::MEM_AW-1:0];  // word address
    mem_o.data = cpu_req_i.wdata;
  end

  assign reg_req_o = cpu_req_i;
  assign reg_sel_o = req_acc && is_reg;

  assign cpu_req_ready_o = ready_q;
  assign cpu_rsp_valid_o = rsp_valid_q;
  assign cpu_rsp_o.rdata = rsp_reg_q ? reg_rdata_i : mem_rdata_i;

  // ready drops for the response cycle of a read
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ready_q <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      ready_q <= !rd_acc;
      rsp_valid_q <= rd_acc;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_acc) rsp_reg_q <= is_reg;
  end

  a_rsp_after_read: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    cpu_rsp_valid_o |-> $past(cpu_req_valid_i && cpu_req_ready_o && !cpu_req_i.write)
  ) else $error("mmio: response without an accepted read");

endmodule

/* hw/pe.sv */
`timescale 1ns/1ns

module pe #(
  parameter logic [7:0] NODE_ADDR = 8'h00
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic cpu_req_valid_i,
  input  pe_pkg::cpu_req_t cpu_req_i,
  output logic cpu_req_ready_o,
  output logic cpu_rsp_valid_o,
  output pe_pkg::cpu_rsp_t cpu_rsp_o,
  output pe_pkg::link_t link_o,
  input  logic credit_i,
  input  pe_pkg::link_t link_i,
  output logic credit_o,
  output logic irq_o
);

  pe_pkg::mem_req_t mem_dma;  // ram port a
  pe_pkg::mem_req_t mem_mmio;  // ram port b
  logic [pe_pkg::MEM_WIDTH-1:0] rdata_dma, rdata_mmio;
  pe_pkg::cpu_req_t reg_req;
  logic reg_sel;
  logic [pe_pkg::MEM_WIDTH-1:0] reg_rdata;
  pe_pkg::ddma_cmd_t cmd;
  logic cmd_valid, cmd_ready;
  logic tx_done, rx_done;

  mmio mmio_mod (
    .clk_i, .rst_n_i,
    .cpu_req_valid_i, .cpu_req_i, .cpu_req_ready_o,
    .cpu_rsp_valid_o, .cpu_rsp_o,
    .mem_o(mem_mmio), .mem_rdata_i(rdata_mmio),
    .reg_req_o(reg_req), .reg_sel_o(reg_sel), .reg_rdata_i(reg_rdata)
  );

  tcd #(.NODE_ADDR(NODE_ADDR)) tcd_mod (
    .clk_i, .rst_n_i,
    .reg_req_i(reg_req), .reg_sel_i(reg_sel), .reg_rdata_o(reg_rdata),
    .cmd_o(cmd), .cmd_valid_o(cmd_valid), .cmd_ready_i(cmd_ready),
    .tx_done_i(tx_done), .rx_done_i(rx_done),
    .irq_o
  );

  // network side sits where the router local port used to be
  ddma #(.NODE_ADDR(NODE_ADDR)) ddma_mod (
    .clk_i, .rst_n_i,
    .cmd_i(cmd), .cmd_valid_i(cmd_valid), .cmd_ready_o(cmd_ready),
    .mem_o(mem_dma), .mem_rdata_i(rdata_dma),
    .link_o, .credit_i,
    .link_i, .credit_o,
    .tx_done_o(tx_done), .rx_done_o(rx_done)
  );

  dual_port_ram memory_mod (
    .clk_i,
    .port_a_i(mem_dma), .port_b_i(mem_mmio),
    .rdata_a_o(rdata_dma), .rdata_b_o(rdata_mmio)
  );

endmodule

/* bench/pe_tb.sv */
`timescale 1ns/1ns

module pe_tb;

  localparam int TIMEOUT = 400;  // cycles allowed per wait loop
  localparam logic [7:0] NODE = 8'h12;

  logic clk = 1'b0;
  logic rst_n_i;
  logic cpu_req_valid_i;
  pe_pkg::cpu_req_t cpu_req_i;
  logic cpu_req_ready_o;
  logic cpu_rsp_valid_o;
  pe_pkg::cpu_rsp_t cpu_rsp_o;
  pe_pkg::link_t link_o;
  logic credit_i;
  pe_pkg::link_t link_i;
  logic credit_o;
  logic irq_o;

  integer seed = 32'h47770be9;
  logic [31:0] model [pe_pkg::MEM_DEPTH];  // expected scratchpad contents
  logic [31:0] sent_flits [$];  // everything seen on link_o
  logic [31:0] pkt_q [$];  // next packet for link_i
  int unsigned delay_tab [64];
  int credits_owed = 0;  // flits on link_o not yet credited back
  int credit_delay = 0;
  int delay_idx = 0;
  int in_flits = 0;
  int credits_back = 0;

  always #50 clk = ~clk;

  pe #(.NODE_ADDR(NODE)) pe_i (
    .clk_i(clk), .rst_n_i,
    .cpu_req_valid_i, .cpu_req_i, .cpu_req_ready_o,
    .cpu_rsp_valid_o, .cpu_rsp_o,
    .link_o, .credit_i,
    .link_i, .credit_o,
    .irq_o
  );

  task automatic stop_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    stop_run();
  endtask

  task automatic timeout_error(input string what);
    $display("Timeout at %0t ns: %s", $time, what);
    stop_run();
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else value_error(name, got, exp);
  endtask

  // every flit into the pe must be paid back by one credit pulse
  a_credit_follows_flit: assert property (
    @(posedge clk) disable iff (!rst_n_i) credit_o |-> $past(link_i.tx)
  ) else value_error("credit_o", credit_o, 0);

  a_ready_low_on_rsp: assert property (
    @(posedge clk) disable iff (!rst_n_i) cpu_rsp_valid_o |-> !cpu_req_ready_o
  ) else value_error("cpu_req_ready_o", cpu_req_ready_o, 0);

  // peer on link_o, hands credits back after a random gap
  always @(posedge clk) begin
    #10;
    if (link_o.tx === 1'b1) begin
      sent_flits.push_back(link_o.data);
      credits_owed++;
      assert (credits_owed <= pe_pkg::LINK_CREDITS)
        else value_error("flits outstanding on link_o", credits_owed, pe_pkg::LINK_CREDITS);
    end
    if (credits_owed > 0 && credit_delay == 0) begin
      credit_i = 1'b1;
      credits_owed--;
      credit_delay = delay_tab[delay_idx];
      delay_idx = (delay_idx + 1) % 64;
    end else begin
      credit_i = 1'b0;
      if (credit_delay > 0) credit_delay--;
    end
  end

  always @(negedge clk) begin
    if (credit_o === 1'b1) credits_back++;
  end

  task automatic next_cycle();
    @(posedge clk);
    #10;  // drive point
  endtask

  function automatic logic [11:0] reg_addr(input pe_pkg::reg_addr_e off);
    return {1'b1, 7'b0, off};
  endfunction

  function automatic logic [11:0] mem_addr(input logic [7:0] a);
    return pe_pkg::MEM_BASE + {4'b0, a};
  endfunction

  function automatic logic [31:0] fill_word(input logic [7:0] a);
    return {a ^ 8'h5a, ~a, a, a + 8'h11};
  endfunction

  task automatic issue_request(input logic write, input logic [11:0] addr,
                               input logic [31:0] wdata);
    int waited;
    waited = 0;
    cpu_req_valid_i = 1'b1;
    cpu_req_i = '{write: write, addr: addr, wdata: wdata};
    while (cpu_req_ready_o !== 1'b1) begin
      next_cycle();
      waited++;
      if (waited > TIMEOUT) timeout_error("cpu_req_ready_o stayed low");
    end
    next_cycle();  // taken at this edge
    cpu_req_valid_i = 1'b0;
  endtask

  task automatic cpu_write(input logic [11:0] addr, input logic [31:0] wdata);
    issue_request(1'b1, addr, wdata);
  endtask

  task automatic cpu_read(input logic [11:0] addr, output logic [31:0] rdata);
    issue_request(1'b0, addr, '0);
    check_value("cpu_rsp_valid_o", cpu_rsp_valid_o, 1);
    rdata = cpu_rsp_o.rdata;
  endtask

  task automatic check_read(input logic [11:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    cpu_read(addr, rd);
    check_value($sformatf("cpu_rsp_o.rdata @%h", addr), rd, exp);
  endtask

  task automatic check_quiet();
    check_value("link_o.tx", link_o.tx, 0);
    check_value("credit_o", credit_o, 0);
    check_value("irq_o", irq_o, 0);
    check_value("cpu_rsp_valid_o", cpu_rsp_valid_o, 0);
  endtask

  task automatic wait_status(input int bit_idx);
    logic [31:0] st;
    int waited;
    waited = 0;
    cpu_read(reg_addr(pe_pkg::REG_STATUS), st);
    while (st[bit_idx] !== 1'b1) begin
      waited++;
      if (waited > TIMEOUT) timeout_error($sformatf("status bit %0d never set", bit_idx));
      cpu_read(reg_addr(pe_pkg::REG_STATUS), st);
    end
  endtask

  task automatic wait_irq(input logic level);
    int waited;
    waited = 0;
    while (irq_o !== level) begin
      next_cycle();
      waited++;
      if (waited > TIMEOUT) timeout_error("irq_o did not reach the expected level");
    end
  endtask

  task automatic wait_flits(input int count);
    int waited;
    waited = 0;
    while (sent_flits.size() < count) begin
      next_cycle();
      waited++;
      if (waited > TIMEOUT) timeout_error("too few flits came out on link_o");
    end
  endtask

  task automatic wait_credits(input int total);
    int waited;
    waited = 0;
    while (credits_back < total) begin
      next_cycle();
      waited++;
      if (waited > TIMEOUT) timeout_error("credit_o pulses missing");
    end
  endtask

  // sends pkt_q on link_i, only while credit is held
  task automatic inject_packet();
    int idx;
    int waited;
    idx = 0;
    waited = 0;
    while (idx < pkt_q.size()) begin
      if (in_flits - credits_back < pe_pkg::LINK_CREDITS) begin
        link_i = '{tx: 1'b1, data: pkt_q[idx]};
        idx++;
        in_flits++;
        waited = 0;
      end else begin
        link_i.tx = 1'b0;
        waited++;
        if (waited > TIMEOUT) timeout_error("no credit came back on credit_o");
      end
      next_cycle();
    end
    link_i = '0;
  endtask

  initial begin
    int i;
    logic [31:0] rd;
    logic [7:0] a;
    logic [7:0] addrs [$];
    pe_pkg::flit_hdr_t hdr;
    rst_n_i = 1'b0;
    cpu_req_valid_i = 1'b0;
    cpu_req_i = '0;
    link_i = '0;
    credit_i = 1'b0;
    for (i = 0; i < 64; i++) delay_tab[i] = {$random(seed)} % 6;

    repeat (4) begin
      next_cycle();
      check_quiet();
    end
    rst_n_i = 1'b1;
    next_cycle();
    check_quiet();
    check_value("cpu_req_ready_o", cpu_req_ready_o, 1);

    for (i = 0; i < pe_pkg::MEM_DEPTH; i++) begin
      model[i] = fill_word(8'(i));
      cpu_write(mem_addr(8'(i)), model[i]);
    end
    for (i = 0; i < 12; i++) begin
      a = 8'($random(seed));
      model[a] = $random(seed);
      cpu_write(mem_addr(a), model[a]);
      addrs.push_back(a);
    end
    foreach (addrs[j]) check_read(mem_addr(addrs[j]), model[addrs[j]]);

    cpu_write(reg_addr(pe_pkg::REG_DEST_NODE), 32'h34);
    cpu_write(reg_addr(pe_pkg::REG_LOCAL_ADDR), 32'h20);
    cpu_write(reg_addr(pe_pkg::REG_REMOTE_ADDR), 32'h90);
    cpu_write(reg_addr(pe_pkg::REG_LENGTH), 32'd7);
    check_read(reg_addr(pe_pkg::REG_DEST_NODE), 32'h34);
    check_read(reg_addr(pe_pkg::REG_LOCAL_ADDR), 32'h20);
    check_read(reg_addr(pe_pkg::REG_REMOTE_ADDR), 32'h90);
    check_read(reg_addr(pe_pkg::REG_LENGTH), 32'd7);

    // send, 7 words so the credit counter runs dry
    cpu_write(reg_addr(pe_pkg::REG_START), 32'h1);
    wait_status(0);
    wait_flits(9);
    hdr = '{opcode: pe_pkg::PKT_WRITE, length: 8'd7, src_node: NODE, dest_node: 8'h34};
    check_value("number of flits on link_o", sent_flits.size(), 9);
    check_value("link_o header flit", sent_flits[0], hdr);
    check_value("link_o address flit", sent_flits[1], 32'h90);
    for (i = 0; i < 7; i++) check_value("link_o data flit", sent_flits[2 + i], model[32 + i]);

    cpu_write(reg_addr(pe_pkg::REG_IRQ_EN), 32'h2);  // rx only, tx_done is pending
    repeat (4) begin
      next_cycle();
      check_value("irq_o", irq_o, 0);
    end
    cpu_write(reg_addr(pe_pkg::REG_IRQ_EN), 32'h3);
    wait_irq(1'b1);
    cpu_write(reg_addr(pe_pkg::REG_IRQ_CLR), 32'h1);
    wait_irq(1'b0);
    cpu_read(reg_addr(pe_pkg::REG_STATUS), rd);
    check_value("REG_STATUS[2:0]", rd[2:0], 3'b000);

    // receive, wraps past the top of the scratchpad
    hdr = '{opcode: pe_pkg::PKT_WRITE, length: 8'd5, src_node: 8'h34, dest_node: NODE};
    pkt_q.delete();
    pkt_q.push_back(hdr);
    pkt_q.push_back(32'h0000_00fd);
    for (i = 0; i < 5; i++) begin
      rd = $random(seed);
      pkt_q.push_back(rd);
      model[(253 + i) % pe_pkg::MEM_DEPTH] = rd;
    end
    inject_packet();
    wait_credits(in_flits);
    wait_irq(1'b1);
    cpu_read(reg_addr(pe_pkg::REG_STATUS), rd);
    check_value("REG_STATUS rx_done", rd[1], 1);
    check_value("credit_o pulses", credits_back, in_flits);
    for (i = 0; i < 5; i++) begin
      a = 8'((253 + i) % pe_pkg::MEM_DEPTH);
      check_read(mem_addr(a), model[a]);
    end
    cpu_write(reg_addr(pe_pkg::REG_IRQ_CLR), 32'h2);
    wait_irq(1'b0);

    // unknown opcode gets swallowed
    hdr = '{opcode: pe_pkg::pkt_type_e'(8'hee), length: 8'd3, src_node: 8'h34, dest_node: NODE};
    pkt_q.delete();
    pkt_q.push_back(hdr);
    pkt_q.push_back(32'h0000_0040);
    for (i = 0; i < 3; i++) pkt_q.push_back($random(seed));
    inject_packet();
    wait_credits(in_flits);
    repeat (3) next_cycle();
    check_value("credit_o pulses", credits_back, in_flits);
    cpu_read(reg_addr(pe_pkg::REG_STATUS), rd);
    check_value("REG_STATUS rx_done", rd[1], 0);
    check_value("irq_o", irq_o, 0);
    for (i = 0; i < 3; i++) check_read(mem_addr(8'(64 + i)), model[64 + i]);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* list.f */
common/pe_pkg.sv
hw/dual_port_ram.sv
hw/ddma/ddma.sv
hw/tcd.sv
hw/mmio.sv
hw/pe.sv
bench/pe_tb.sv

/* Bender.yml */
package:
  name: pe

sources:
  - common/pe_pkg.sv
  - hw/dual_port_ram.sv
  - hw/ddma/ddma.sv
  - hw/tcd.sv
  - hw/mmio.sv
  - hw/pe.sv
  - target: test
    files:
      - bench/pe_tb.sv
